//--- lcd_clock_pkg.sv
`default_nettype none

package lcd_clock_pkg;

	typedef struct packed {
		logic [3:0] hour_tens; // 0..2
		logic [3:0] hour_ones; // 0..9, 0..3 when tens is 2
		logic [3:0] min_tens;  // 0..5
		logic [3:0] min_ones;  // 0..9
		logic [3:0] sec_tens;  // 0..5
		logic [3:0] sec_ones;  // 0..9
	} bcd_time_t;

	typedef struct packed {
		logic set_sec;  // one cycle per debounced press
		logic set_min;
		logic set_hour;
	} key_event_t;

	typedef struct packed {
		logic       rs;   // 0 command, 1 character
		logic [7:0] data;
	} lcd_byte_t;

	typedef struct packed {
		logic       rs;
		logic       en;
		logic [7:0] db;
	} lcd_bus_t;

	// hd44780 commands, 8-bit mode
	localparam logic [7:0] LCD_FUNCTION_SET = 8'h38; // 8 bit, 2 lines, 5x8
	localparam logic [7:0] LCD_DISPLAY_ON   = 8'h0C; // display on, no cursor
	localparam logic [7:0] LCD_CLEAR        = 8'h01; // slow, needs the long wait
	localparam logic [7:0] LCD_ENTRY_MODE   = 8'h06; // increment, no shift
	localparam logic [7:0] LCD_LINE1_ADDR   = 8'h80; // ddram address 0

	localparam logic [7:0] ASCII_ZERO  = 8'h30;
	localparam logic [7:0] ASCII_COLON = 8'h3A;

	// en strobe shape in clock cycles, 2 + 3 + 3 = eight phases
	localparam int EN_SETUP_CYCLES = 2;
	localparam int EN_HIGH_CYCLES  = 3;
	localparam int EN_HOLD_CYCLES  = 3;

endpackage

`default_nettype wire

//--- key_debounce.sv
`timescale 1ns/1ns
`default_nettype none

module key_debounce #(
	parameter int DEBOUNCE_CYCLES = 500_000 // 10 ms at 50 MHz
) (
	input  logic                      clk_50M,
	input  logic                      reset_n,
	input  logic [2:0]                keys,    // active low, bit 0 sec, 1 min, 2 hour
	output lcd_clock_pkg::key_event_t presses
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [2:0]       sync_1;          // first sync stage
	logic [2:0]       sync_2;          // second sync stage
	logic [2:0]       level;           // debounced level, 1 = released
	logic [2:0]       level_d;         // level one cycle late, for edge detect
	logic [CNT_W-1:0] stable_cnt [3];  // cycles the raw key has differed from level

	always_ff @(posedge clk_50M or negedge reset_n)
	begin
		if (!reset_n)
		begin
			sync_1  <= 3'b111; // keys read as released
			sync_2  <= 3'b111;
			level   <= 3'b111;
			level_d <= 3'b111;
			presses <= '0;
			for (int i = 0; i < 3; i++)
			begin
				stable_cnt[i] <= '0;
			end
		end
		else
		begin
			sync_1  <= keys;
			sync_2  <= sync_1;
			level_d <= level;
			for (int i = 0; i < 3; i++)
			begin
				if (sync_2[i] == level[i])
					stable_cnt[i] <= '0; // bounce back, start over
				else if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1))
				begin
					level[i]      <= sync_2[i]; // stable long enough
					stable_cnt[i] <= '0;
				end
				else
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
			end
			// falling debounced level gives a press, one cycle after the fall
			presses.set_sec  <= level_d[0] & ~level[0];
			presses.set_min  <= level_d[1] & ~level[1];
			presses.set_hour <= level_d[2] & ~level[2];
		end
	end

endmodule

`default_nettype wire

//--- time_keeper.sv
`timescale 1ns/1ns
`default_nettype none

module time_keeper #(
	parameter int TICK_CYCLES = 50_000_000 // one second at 50 MHz
) (
	input  logic                      clk_50M,
	input  logic                      reset_n,
	input  lcd_clock_pkg::key_event_t presses,
	output lcd_clock_pkg::bcd_time_t  now_time
);
	import lcd_clock_pkg::*;

	localparam int PRESC_W = $clog2(TICK_CYCLES + 1);

	logic [PRESC_W-1:0] presc;     // one-second prescaler
	logic               tick;
	key_event_t         pending;   // press that met a tick
	key_event_t         req;       // pending plus new presses
	key_event_t         sel;       // single press after priority
	logic [7:0]         sec_pair;  // {tens, ones}
	logic [7:0]         min_pair;
	logic [7:0]         hour_pair;

	// 00..59 step, wraps without carry out
	function automatic logic [7:0] inc_sexa(input logic [7:0] pair);
		if (pair[3:0] != 4'd9)
			return {pair[7:4], pair[3:0] + 4'd1};
		else if (pair[7:4] != 4'd5)
			return {pair[7:4] + 4'd1, 4'd0};
		else
			return 8'h00;
	endfunction

	// 00..23 step
	function automatic logic [7:0] inc_hour(input logic [7:0] pair);
		if (pair == 8'h23)
			return 8'h00;
		else if (pair[3:0] == 4'd9)
			return {pair[7:4] + 4'd1, 4'd0};
		else
			return {pair[7:4], pair[3:0] + 4'd1};
	endfunction

	assign tick      = (presc == PRESC_W'(TICK_CYCLES - 1));
	assign sec_pair  = {now_time.sec_tens, now_time.sec_ones};
	assign min_pair  = {now_time.min_tens, now_time.min_ones};
	assign hour_pair = {now_time.hour_tens, now_time.hour_ones};

	always_comb
	begin
		req = pending | presses;
		sel = '0;
		if (req.set_sec)
			sel.set_sec = 1'b1; // seconds win
		else if (req.set_min)
			sel.set_min = 1'b1;
		else if (req.set_hour)
			sel.set_hour = 1'b1;
	end

	always_ff @(posedge clk_50M or negedge reset_n)
	begin
		if (!reset_n)
		begin
			presc    <= '0;
			pending  <= '0;
			now_time <= '0; // 00:00:00
		end
		else
		begin
			presc <= tick ? '0 : presc + 1'b1;
			if (tick)
			begin
				pending <= sel; // press waits one cycle for the tick
				{now_time.sec_tens, now_time.sec_ones} <= inc_sexa(sec_pair);
				if (sec_pair == 8'h59)
				begin
					{now_time.min_tens, now_time.min_ones} <= inc_sexa(min_pair);
					if (min_pair == 8'h59)
						{now_time.hour_tens, now_time.hour_ones} <= inc_hour(hour_pair);
				end
			end
			else
			begin
				pending <= '0;
				if (sel.set_sec)
					{now_time.sec_tens, now_time.sec_ones} <= inc_sexa(sec_pair);
				else if (sel.set_min)
					{now_time.min_tens, now_time.min_ones} <= inc_sexa(min_pair);
				else if (sel.set_hour)
					{now_time.hour_tens, now_time.hour_ones} <= inc_hour(hour_pair);
			end
		end
	end

endmodule

`default_nettype wire

//--- lcd_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_sequencer #(
	parameter int POWER_ON_CYCLES = 2_000_000 // 40 ms at 50 MHz
) (
	input  logic                     clk_50M,
	input  logic                     reset_n,
	input  lcd_clock_pkg::bcd_time_t now_time,
	output lcd_clock_pkg::lcd_byte_t byte_data,
	output logic                     byte_valid,
	input  logic                     byte_ready
);
	import lcd_clock_pkg::*;

	localparam int PWR_W = $clog2(POWER_ON_CYCLES + 1);

	typedef enum logic [1:0] {
		PH_POWER, // lcd power-on wait
		PH_INIT,  // four init commands
		PH_ADDR,  // line 1 address
		PH_CHAR   // eight characters
	} phase_t;

	phase_t           phase;
	logic [PWR_W-1:0] power_cnt;
	logic [2:0]       step;       // init command or character index
	bcd_time_t        frame_time; // time shown by the current frame
	logic             power_done;
	logic             xfer;

	function automatic logic [7:0] init_cmd(input logic [1:0] idx);
		case (idx)
			2'd0:    return LCD_FUNCTION_SET;
			2'd1:    return LCD_DISPLAY_ON;
			2'd2:    return LCD_CLEAR;
			default: return LCD_ENTRY_MODE;
		endcase
	endfunction

	// H H : M M : S S
	function automatic logic [7:0] frame_char(input bcd_time_t t, input logic [2:0] idx);
		case (idx)
			3'd0:    return ASCII_ZERO + {4'd0, t.hour_tens};
			3'd1:    return ASCII_ZERO + {4'd0, t.hour_ones};
			3'd3:    return ASCII_ZERO + {4'd0, t.min_tens};
			3'd4:    return ASCII_ZERO + {4'd0, t.min_ones};
			3'd6:    return ASCII_ZERO + {4'd0, t.sec_tens};
			3'd7:    return ASCII_ZERO + {4'd0, t.sec_ones};
			default: return ASCII_COLON;
		endcase
	endfunction

	assign power_done = (phase == PH_POWER) && (power_cnt == PWR_W'(POWER_ON_CYCLES - 1));
	assign xfer       = byte_valid && byte_ready;

	always_ff @(posedge clk_50M or negedge reset_n)
	begin
		if (!reset_n)
		begin
			phase      <= PH_POWER;
			power_cnt  <= '0;
			step       <= '0;
			byte_valid <= 1'b0;
		end
		else if (power_done)
		begin
			phase      <= PH_INIT;
			step       <= '0;
			byte_valid <= 1'b1; // valid from here on, bytes back to back
		end
		else if (phase == PH_POWER)
			power_cnt <= power_cnt + 1'b1;
		else if (xfer)
		begin
			case (phase)
				PH_INIT:
				begin
					step  <= (step == 3'd3) ? 3'd0 : step + 3'd1;
					phase <= (step == 3'd3) ? PH_ADDR : PH_INIT;
				end
				PH_ADDR:
				begin
					step  <= '0;
					phase <= PH_CHAR;
				end
				default:
				begin
					step  <= step + 3'd1; // wraps to 0 after the last char
					phase <= (step == 3'd7) ? PH_ADDR : PH_CHAR;
				end
			endcase
		end
	end

	// next byte set up at each transfer
	always_ff @(posedge clk_50M)
	begin
		if (power_done)
			byte_data <= '{rs: 1'b0, data: init_cmd(2'd0)};
		else if (xfer)
		begin
			case (phase)
				PH_INIT:
					if (step == 3'd3)
						byte_data <= '{rs: 1'b0, data: LCD_LINE1_ADDR};
					else
						byte_data <= '{rs: 1'b0, data: init_cmd(step[1:0] + 2'd1)};
				PH_ADDR:
				begin
					frame_time <= now_time; // frozen for the whole frame
					byte_data  <= '{rs: 1'b1, data: frame_char(now_time, 3'd0)};
				end
				PH_CHAR:
					if (step == 3'd7)
						byte_data <= '{rs: 1'b0, data: LCD_LINE1_ADDR};
					else
						byte_data <= '{rs: 1'b1, data: frame_char(frame_time, step + 3'd1)};
				default:
					byte_data <= byte_data;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- lcd_bus_writer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_bus_writer #(
	parameter int CMD_WAIT_CYCLES   = 2_500,  // 50 us
	parameter int CLEAR_WAIT_CYCLES = 90_000  // 1.8 ms for clear
) (
	input  logic                     clk_50M,
	input  logic                     reset_n,
	input  lcd_clock_pkg::lcd_byte_t byte_data,
	input  logic                     byte_valid,
	output logic                     byte_ready,
	output lcd_clock_pkg::lcd_bus_t  lcd_bus
);
	import lcd_clock_pkg::*;

	localparam int STROBE_LEN = EN_SETUP_CYCLES + EN_HIGH_CYCLES + EN_HOLD_CYCLES;
	localparam int PH_W       = $clog2(STROBE_LEN);
	localparam int WAIT_MAX   = (CLEAR_WAIT_CYCLES > CMD_WAIT_CYCLES) ?
		CLEAR_WAIT_CYCLES : CMD_WAIT_CYCLES;
	localparam int WAIT_W     = $clog2(WAIT_MAX + 1);

	typedef enum logic [1:0] {
		ST_IDLE,   // ready for a byte
		ST_STROBE, // setup, en high, hold
		ST_WAIT    // lcd executes the byte
	} wr_state_t;

	wr_state_t         state;
	logic [PH_W-1:0]   phase_cnt;
	logic [PH_W-1:0]   phase_next;
	logic [WAIT_W-1:0] wait_cnt;
	logic [WAIT_W-1:0] wait_last;  // last wait cycle for this byte
	logic              clear_q;    // byte was the clear command
	logic              xfer;

	assign byte_ready = (state == ST_IDLE);
	assign xfer       = byte_valid && byte_ready;
	assign phase_next = phase_cnt + 1'b1;
	assign wait_last  = clear_q ? WAIT_W'(CLEAR_WAIT_CYCLES - 1) : WAIT_W'(CMD_WAIT_CYCLES - 1);

	always_ff @(posedge clk_50M or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state     <= ST_IDLE;
			phase_cnt <= '0;
			wait_cnt  <= '0;
			clear_q   <= 1'b0;
			lcd_bus   <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (xfer)
					begin
						lcd_bus.rs <= byte_data.rs; // held until next byte
						lcd_bus.db <= byte_data.data;
						lcd_bus.en <= 1'b0;
						clear_q    <= !byte_data.rs && (byte_data.data == LCD_CLEAR);
						phase_cnt  <= '0;
						state      <= ST_STROBE;
					end
				ST_STROBE:
				begin
					phase_cnt  <= phase_next;
					// en high in the middle phases only
					lcd_bus.en <= (phase_next >= PH_W'(EN_SETUP_CYCLES)) &&
						(phase_next < PH_W'(EN_SETUP_CYCLES + EN_HIGH_CYCLES));
					if (phase_cnt == PH_W'(STROBE_LEN - 1))
					begin
						wait_cnt <= '0;
						state    <= ST_WAIT;
					end
				end
				ST_WAIT:
					if (wait_cnt == wait_last)
						state <= ST_IDLE; // ready in the next cycle
					else
						wait_cnt <= wait_cnt + 1'b1;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- lcd_clock.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_clock #(
	parameter int TICK_CYCLES       = 50_000_000, // 1 s
	parameter int DEBOUNCE_CYCLES   = 500_000,    // 10 ms
	parameter int POWER_ON_CYCLES   = 2_000_000,  // 40 ms
	parameter int CMD_WAIT_CYCLES   = 2_500,      // 50 us
	parameter int CLEAR_WAIT_CYCLES = 90_000      // 1.8 ms
) (
	input  logic                    clk_50M,
	input  logic                    reset_n,
	input  logic [2:0]              keys,    // active low, sec, min, hour
	output lcd_clock_pkg::lcd_bus_t lcd_bus
);
	import lcd_clock_pkg::*;

	key_event_t presses;
	bcd_time_t  now_time;
	lcd_byte_t  byte_data;
	logic       byte_valid;
	logic       byte_ready;

	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) key_debounce_i (
		.clk_50M (clk_50M),
		.reset_n (reset_n),
		.keys    (keys),
		.presses (presses)
	);

	time_keeper #(.TICK_CYCLES(TICK_CYCLES)) time_keeper_i (
		.clk_50M  (clk_50M),
		.reset_n  (reset_n),
		.presses  (presses),
		.now_time (now_time)
	);

	lcd_sequencer #(.POWER_ON_CYCLES(POWER_ON_CYCLES)) lcd_sequencer_i (
		.clk_50M    (clk_50M),
		.reset_n    (reset_n),
		.now_time   (now_time),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_ready (byte_ready)
	);

	lcd_bus_writer #(
		.CMD_WAIT_CYCLES   (CMD_WAIT_CYCLES),
		.CLEAR_WAIT_CYCLES (CLEAR_WAIT_CYCLES)
	) lcd_bus_writer_i (
		.clk_50M    (clk_50M),
		.reset_n    (reset_n),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_ready (byte_ready),
		.lcd_bus    (lcd_bus)
	);

endmodule

`default_nettype wire

//--- lcd_clock_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_clock_assertions (
	input logic                    clk_50M,
	input logic                    reset_n,
	input lcd_clock_pkg::lcd_bus_t lcd_bus
);
	import lcd_clock_pkg::*;

	int high_cnt; // cycles en has been high so far

	always_ff @(posedge clk_50M or negedge reset_n)
	begin
		if (!reset_n)
			high_cnt <= 0;
		else if (lcd_bus.en)
			high_cnt <= high_cnt + 1;
		else
			high_cnt <= 0;
	end

	en_width_a: assert property (@(posedge clk_50M) disable iff (!reset_n)
		$fell(lcd_bus.en) |-> high_cnt == EN_HIGH_CYCLES)
		else $error("en pulse lasted %0d cycles", high_cnt);

	en_max_a: assert property (@(posedge clk_50M) disable iff (!reset_n)
		lcd_bus.en |-> high_cnt < EN_HIGH_CYCLES)
		else $error("en high too long");

	// lcd latches on the en fall, data must not move while en is up
	data_stable_a: assert property (@(posedge clk_50M) disable iff (!reset_n)
		lcd_bus.en |-> $stable(lcd_bus.rs) && $stable(lcd_bus.db))
		else $error("rs or db changed while en high");

	en_reset_a: assert property (@(posedge clk_50M) !reset_n |-> !lcd_bus.en)
		else $error("en high during reset");

endmodule

bind lcd_bus_writer lcd_clock_assertions bus_checks_i (
	.clk_50M (clk_50M),
	.reset_n (reset_n),
	.lcd_bus (lcd_bus)
);

`default_nettype wire

//--- lcd_clock_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_clock_tb;
	import lcd_clock_pkg::*;

	localparam int TICK_CYCLES       = 3000;
	localparam int DEBOUNCE_CYCLES   = 8;
	localparam int POWER_ON_CYCLES   = 100;
	localparam int CMD_WAIT_CYCLES   = 5;
	localparam int CLEAR_WAIT_CYCLES = 40;
	localparam int HOLD_CYCLES       = DEBOUNCE_CYCLES + 6; // key level held past debounce
	localparam int BYTE_TIMEOUT      = 400;                 // power-on plus clear wait fit
	localparam int DAY_SECONDS       = 86400;
	localparam int KEY_SEC           = 0;
	localparam int KEY_MIN           = 1;
	localparam int KEY_HOUR          = 2;

	logic       clk_50M = 1'b0;
	logic       reset_n;
	logic [2:0] keys;                // active low
	lcd_bus_t   lcd_bus;

	lcd_byte_t  rx_q [$];            // bytes seen on the bus
	int         cyc_q [$];           // cycle of each captured byte
	int         rd_idx = 0;          // next byte to read
	int         cycle_cnt = 0;       // clocks since reset release
	int         first_en_cycle = -1; // cycle of the first en rise
	logic       en_q = 1'b0;
	int         error_count = 0;
	int         check_count = 0;
	int         seed_val;

	lcd_clock #(
		.TICK_CYCLES       (TICK_CYCLES),
		.DEBOUNCE_CYCLES   (DEBOUNCE_CYCLES),
		.POWER_ON_CYCLES   (POWER_ON_CYCLES),
		.CMD_WAIT_CYCLES   (CMD_WAIT_CYCLES),
		.CLEAR_WAIT_CYCLES (CLEAR_WAIT_CYCLES)
	) dut_i (
		.clk_50M (clk_50M),
		.reset_n (reset_n),
		.keys    (keys),
		.lcd_bus (lcd_bus)
	);

	always #10 clk_50M = ~clk_50M; // 50 MHz

	// bus monitor, one entry per en fall
	always @(posedge clk_50M)
	begin
		if (reset_n)
		begin
			if (lcd_bus.en && !en_q && first_en_cycle < 0)
				first_en_cycle <= cycle_cnt;
			if (en_q && !lcd_bus.en)
			begin
				rx_q.push_back({lcd_bus.rs, lcd_bus.db});
				cyc_q.push_back(cycle_cnt);
			end
			en_q      <= lcd_bus.en;
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	task automatic finish_run();
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		error_count++;
		$display("Timeout: %s", what);
		finish_run();
	endtask

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			error_count++;
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		check_count++;
		assert (ok)
		else
		begin
			error_count++;
			$display("Error: %s", what);
		end
	endtask

	task automatic read_byte(output lcd_byte_t b, output int cyc);
		int waited;
		waited = 0;
		while (rd_idx >= rx_q.size() && waited < BYTE_TIMEOUT)
		begin
			@(posedge clk_50M);
			#1;
			waited++;
		end
		if (rd_idx >= rx_q.size())
			fail_timeout("no byte was written to the LCD");
		else
		begin
			b   = rx_q[rd_idx];
			cyc = cyc_q[rd_idx];
			rd_idx++;
		end
	endtask

	task automatic flush_bytes();
		rd_idx = rx_q.size(); // drop anything already seen
	endtask

	// strict: the frame must start at the very next byte
	task automatic read_frame(input bit strict, output int secs, output int cyc);
		lcd_byte_t  b;
		int         c;
		int         skipped;
		int         d [8];
		logic [7:0] ch [8];
		skipped = 0;
		read_byte(b, cyc);
		while (!strict && !(b.rs == 1'b0 && b.data == 8'h80) && skipped < 9)
		begin
			skipped++; // tail of a frame cut by a flush
			read_byte(b, cyc);
		end
		check_hex("frame address {rs,db}", {b.rs, b.data}, {1'b0, 8'h80});
		for (int i = 0; i < 8; i++)
		begin
			read_byte(b, c);
			check_hex("char rs", b.rs, 1'b1);
			ch[i] = b.data;
			d[i]  = int'(b.data) - 'h30;
			if (i != 2 && i != 5)
				check_true(b.data >= 8'h30 && b.data <= 8'h39, "non-digit character in a frame");
		end
		check_hex("first colon db", ch[2], 8'h3A);
		check_hex("second colon db", ch[5], 8'h3A);
		check_true(d[0] * 10 + d[1] < 24, "hour out of range");
		check_true(d[3] < 6 && d[6] < 6, "minute or second out of range");
		secs = (d[0] * 10 + d[1]) * 3600 + (d[3] * 10 + d[4]) * 60 + d[6] * 10 + d[7];
	endtask

	function automatic int field_of(input int secs, input int idx);
		case (idx)
			KEY_SEC: return secs % 60;
			KEY_MIN: return (secs / 60) % 60;
			default: return secs / 3600;
		endcase
	endfunction

	// equal or one second later
	task automatic check_step(input int prev, input int cur);
		check_hex("displayed seconds of day", cur, (cur == prev) ? prev : (prev + 1) % DAY_SECONDS);
	endtask

	// pure ticking, the frame is latched a few cycles before its address byte
	task automatic check_time_model(input int secs, input int cyc);
		int lo;
		int hi;
		lo = (cyc - 8) / TICK_CYCLES;
		hi = cyc / TICK_CYCLES;
		check_hex("displayed seconds vs ticks", secs, (secs == lo) ? lo : hi);
	endtask

	task automatic drive_keys(input logic [2:0] val, input int cycles);
		repeat (cycles)
		begin
			@(posedge clk_50M);
			#2 keys = val;
		end
	endtask

	task automatic press_key(input int idx);
		drive_keys(~(3'b001 << idx), HOLD_CYCLES);
		drive_keys(3'b111, HOLD_CYCLES);
	endtask

	// start just after a tick, ~2900 quiet cycles follow
	task automatic wait_tick_window();
		int waited;
		waited = 0;
		do
		begin
			@(posedge clk_50M);
			#1;
			waited++;
		end
		while (cycle_cnt % TICK_CYCLES != 50 && waited < TICK_CYCLES + 10);
		if (cycle_cnt % TICK_CYCLES != 50)
			fail_timeout("tick window never reached");
		else
			flush_bytes(); // frames latched before the window are stale
	endtask

	// press until the field lands in lo..hi
	task automatic key_to(input int idx, input int lo, input int hi);
		int  t;
		int  cyc;
		int  tries;
		bit  done;
		tries = 0;
		done  = 1'b0;
		while (!done && tries < 70)
		begin
			flush_bytes();
			read_frame(1'b0, t, cyc);
			if (field_of(t, idx) >= lo && field_of(t, idx) <= hi)
				done = 1'b1;
			else
				press_key(idx);
			tries++;
		end
		if (!done)
			fail_timeout("time field could not be keyed to its target");
	endtask

	task automatic test_init();
		lcd_byte_t  b;
		int         cyc;
		logic [7:0] init_bytes [4];
		init_bytes = '{8'h38, 8'h0C, 8'h01, 8'h06};
		for (int i = 0; i < 4; i++)
		begin
			read_byte(b, cyc);
			check_hex("init db", b.data, init_bytes[i]);
			check_hex("init rs", b.rs, 1'b0);
		end
		check_true(first_en_cycle >= POWER_ON_CYCLES, "EN pulsed during the power-on wait");
	endtask

	task automatic test_frame();
		int t;
		int cyc;
		read_frame(1'b1, t, cyc);
		check_hex("first frame seconds of day", t, 0); // 00:00:00
		repeat (2)
		begin
			read_frame(1'b1, t, cyc); // back to back
			check_time_model(t, cyc);
		end
	endtask

	task automatic test_ticking();
		int start;
		int prev;
		int cur;
		int cyc;
		int frames;
		read_frame(1'b1, start, cyc);
		prev   = start;
		frames = 0;
		while (prev < start + 3 && frames < 200)
		begin
			read_frame(1'b1, cur, cyc);
			check_step(prev, cur);
			check_time_model(cur, cyc);
			prev = cur;
			frames++;
		end
		if (prev < start + 3)
			fail_timeout("clock did not advance by three seconds");
	endtask

	task automatic test_keys();
		int t0;
		int t1;
		int t2;
		int cyc;
		read_frame(1'b1, t0, cyc);
		check_hex("hour before presses", field_of(t0, KEY_HOUR), 0);
		repeat (25)
			press_key(KEY_HOUR);
		flush_bytes();
		read_frame(1'b0, t1, cyc);
		check_hex("hour after 25 presses", field_of(t1, KEY_HOUR), 1);
		check_hex("minute after hour presses", field_of(t1, KEY_MIN), field_of(t0, KEY_MIN));
		repeat (60)
			press_key(KEY_MIN);
		flush_bytes();
		read_frame(1'b0, t2, cyc);
		check_hex("minute after 60 presses", field_of(t2, KEY_MIN), field_of(t1, KEY_MIN));
		check_hex("hour after minute presses", field_of(t2, KEY_HOUR), 1);
		wait_tick_window();
		read_frame(1'b0, t0, cyc);
		press_key(KEY_SEC);
		flush_bytes();
		read_frame(1'b0, t1, cyc);
		check_hex("seconds after one press", field_of(t1, KEY_SEC), (field_of(t0, KEY_SEC) + 1) % 60);
		check_hex("minutes of day after seconds press", t1 / 60, t0 / 60);
	endtask

	task automatic test_debounce();
		int t0;
		int t1;
		int cyc;
		int mm;
		wait_tick_window();
		read_frame(1'b0, t0, cyc);
		repeat (6)
		begin
			drive_keys(3'b101, 1 + int'($urandom % (DEBOUNCE_CYCLES - 1))); // short low glitch
			drive_keys(3'b111, 1 + int'($urandom % DEBOUNCE_CYCLES));
		end
		drive_keys(3'b111, HOLD_CYCLES);
		flush_bytes();
		read_frame(1'b0, t1, cyc);
		check_hex("time after glitches", t1, t0);
		wait_tick_window();
		read_frame(1'b0, t0, cyc);
		repeat (5)
		begin
			drive_keys(3'b101, 1 + int'($urandom % (DEBOUNCE_CYCLES - 1)));
			drive_keys(3'b111, 1 + int'($urandom % (DEBOUNCE_CYCLES - 1)));
		end
		drive_keys(3'b101, HOLD_CYCLES); // settles pressed
		repeat (4)
		begin
			drive_keys(3'b111, 1 + int'($urandom % (DEBOUNCE_CYCLES - 1))); // release bounce
			drive_keys(3'b101, 1 + int'($urandom % (DEBOUNCE_CYCLES - 1)));
		end
		drive_keys(3'b111, HOLD_CYCLES);
		flush_bytes();
		read_frame(1'b0, t1, cyc);
		mm = field_of(t0, KEY_MIN);
		check_hex("time after bounced press", t1, t0 - mm * 60 + ((mm + 1) % 60) * 60);
	endtask

	task automatic test_rollover();
		int  prev;
		int  cur;
		int  cyc;
		int  frames;
		bit  wrapped;
		key_to(KEY_HOUR, 23, 23);
		key_to(KEY_MIN, 59, 59);
		key_to(KEY_SEC, 50, 56);
		flush_bytes();
		read_frame(1'b0, prev, cyc);
		check_hex("hour and minute before rollover", prev / 60, 23 * 60 + 59);
		frames  = 0;
		wrapped = 1'b0;
		while (!wrapped && frames < 400)
		begin
			read_frame(1'b1, cur, cyc);
			check_step(prev, cur);
			if (prev == DAY_SECONDS - 1 && cur != prev)
			begin
				check_hex("time after 23:59:59", cur, 0);
				wrapped = 1'b1;
			end
			prev = cur;
			frames++;
		end
		if (!wrapped)
			fail_timeout("display never rolled over past 23:59:59");
	endtask

	initial
	begin
		reset_n  = 1'b0;
		keys     = 3'b111; // released
		seed_val = $urandom(54405);
		repeat (8)
			@(posedge clk_50M);
		#2 reset_n = 1'b1;
		test_init();
		test_frame();
		test_ticking();
		test_keys();
		test_debounce();
		test_rollover();
		finish_run();
	end

endmodule

`default_nettype wire

//--- lcd_clock.f
lcd_clock_pkg.sv
key_debounce.sv
time_keeper.sv
lcd_sequencer.sv
lcd_bus_writer.sv
lcd_clock.sv
lcd_clock_assertions.sv
lcd_clock_tb.sv

//--- Makefile
# Verilator simulation of the LCD clock testbench

VERILATOR ?= verilator
TOP       ?= lcd_clock_tb
FILELIST  ?= lcd_clock.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

.PHONY: sim clean

# pass only when the pass line appears in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
